/* src.f */
+incdir+include
logic/bpmSignalPkg.sv
logic/bpmStreamPkg.sv
logic/turnSequencer.sv
logic/demodMixer.sv
logic/turnAccumulator.sv
logic/sqrtMagnitude.sv
logic/magnitudeArbiter.sv
logic/bpmProcessingTop.sv
bench/bpmProcessingTb.sv

/* run.sh */
#!/bin/sh
# builds and runs the BPM processing testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module bpmProcessingTb -f src.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/VbpmProcessingTb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS PASSED" "$LOG"; then
    exit 0
fi
exit 1

/* bench/bpmProcessingTb.sv */
`timescale 1ns/1ns
// BPM processing testbench
// tone, sum shift and random stimulus checked against a model of both streams

module bpmProcessingTb
    import bpmSignalPkg::*, bpmStreamPkg::*;
();

    localparam int toneTurns = 4;
    localparam int shiftTurns = 4;
    localparam int randomTurns = 20;
    localparam int totalTurns = toneTurns + shiftTurns + randomTurns;
    localparam int sampleGap = 32;
    localparam int strobeTimeout = 2000;

    logic                  clk;
    logic                  rstN;
    logic                  adcValid;
    adcVecT                adc;
    logic [shiftWidth-1:0] tbtSumShift;
    logic [shiftWidth-1:0] rfSumShift;
    logic                  tbtMagValid;
    logic                  rfMagValid;
    magVecT                tbtMags;
    magVecT                rfMags;

    // history of every sample sent with its shifts and turn names
    int    sampleQ[$];
    int    tbtShiftQ[$];
    int    rfShiftQ[$];
    string turnNameQ[$];

    int ampC [nAdc];
    int ampS [nAdc];
    int nextSample [nAdc];
    int seed;
    int sentCount;
    int checkCount;
    int errorCount;
    bit timedOut;

    bpmProcessingTop i_bpmProcessingTop (
        .clk         (clk),
        .rstN        (rstN),
        .adcValid    (adcValid),
        .adc         (adc),
        .tbtSumShift (tbtSumShift),
        .rfSumShift  (rfSumShift),
        .tbtMagValid (tbtMagValid),
        .rfMagValid  (rfMagValid),
        .tbtMags     (tbtMags),
        .rfMags      (rfMags)
    );

    always #5 clk = ~clk;

    //////////////////////////////
    // reference model
    //////////////////////////////

    function automatic longint loCos(input int ph);
        case (ph % 4)
            0: return longint'(loAmplitude);
            2: return -longint'(loAmplitude);
            default: return 0;
        endcase
    endfunction

    function automatic longint loSin(input int ph);
        case (ph % 4)
            1: return longint'(loAmplitude);
            3: return -longint'(loAmplitude);
            default: return 0;
        endcase
    endfunction

    function automatic longint refMagnitude(input int first, input int count, input int ch,
                                            input int shift);
        longint sumMax;
        longint magMax;
        longint sumI;
        longint sumQ;
        longint sample;
        longint power;
        longint root;
        longint trialRoot;
        sumMax = (longint'(1) <<< (sumWidth - 1)) - 1;
        magMax = (longint'(1) <<< magWidth) - 1;
        sumI = 0;
        sumQ = 0;
        for (int k = first; k < first + count; k++) begin
            sample = longint'(sampleQ[k * nAdc + ch]);
            sumI += (sample * loCos(k % samplesPerTurn)) >>> productShift;
            sumQ += (sample * loSin(k % samplesPerTurn)) >>> productShift;
        end
        sumI = sumI >>> shift;
        sumQ = sumQ >>> shift;
        // clamp to the signed sum range
        if (sumI > sumMax) begin
            sumI = sumMax;
        end else if (sumI < -sumMax - 1) begin
            sumI = -sumMax - 1;
        end
        if (sumQ > sumMax) begin
            sumQ = sumMax;
        end else if (sumQ < -sumMax - 1) begin
            sumQ = -sumMax - 1;
        end
        power = sumI * sumI + sumQ * sumQ;
        root = 0;
        for (int b = magWidth; b >= 0; b--) begin
            trialRoot = root | (longint'(1) <<< b);
            if (trialRoot * trialRoot <= power) begin
                root = trialRoot;
            end
        end
        if (root > magMax) begin
            root = magMax;
        end
        return root;
    endfunction

    //////////////////////////////
    // stimulus
    //////////////////////////////

    task automatic driveSample();
        @(posedge clk);
        #1;
        adcValid = 1'b1;
        for (int ch = 0; ch < nAdc; ch++) begin
            adc[ch] = adcSampleT'(nextSample[ch]);
            sampleQ.push_back(nextSample[ch]);
        end
        tbtShiftQ.push_back(int'(tbtSumShift));
        rfShiftQ.push_back(int'(rfSumShift));
        sentCount++;
        @(posedge clk);
        #1;
        adcValid = 1'b0;
        repeat (sampleGap - 2) @(posedge clk);
        #1;
    endtask

    // quarter rate tone with per channel amplitude and phase from ampC and ampS
    task automatic sendToneTurns(input string name, input int turns);
        for (int t = 0; t < turns; t++) begin
            turnNameQ.push_back(name);
            for (int s = 0; s < samplesPerTurn; s++) begin
                for (int ch = 0; ch < nAdc; ch++) begin
                    case (s % 4)
                        0: nextSample[ch] = ampC[ch];
                        1: nextSample[ch] = ampS[ch];
                        2: nextSample[ch] = -ampC[ch];
                        default: nextSample[ch] = -ampS[ch];
                    endcase
                end
                driveSample();
            end
        end
    endtask

    task automatic sendRandomTurns(input string name, input int turns);
        for (int t = 0; t < turns; t++) begin
            turnNameQ.push_back(name);
            for (int s = 0; s < samplesPerTurn; s++) begin
                for (int ch = 0; ch < nAdc; ch++) begin
                    nextSample[ch] = int'(adcSampleT'($random(seed)));
                end
                driveSample();
            end
        end
    endtask

    //////////////////////////////
    // comparison
    //////////////////////////////

    task automatic awaitStrobe(input bit wantRf, input int turn, output bit arrived);
        int cycles;
        cycles = 0;
        arrived = 1'b0;
        while (!arrived && cycles < strobeTimeout) begin
            @(negedge clk);
            cycles++;
            arrived = tbtMagValid || rfMagValid;
        end
        if (!arrived) begin
            timedOut = 1'b1;
            errorCount++;
            $display("no %s magnitude strobe for turn %0d within %0d cycles",
                     wantRf ? "RF" : "TBT", turn, strobeTimeout);
        end else begin
            assert (rfMagValid == wantRf && tbtMagValid == !wantRf) else begin
                errorCount++;
                $display("wrong magnitude strobe at turn %0d, expected the %s strobe",
                         turn, wantRf ? "RF" : "TBT");
            end
            assert (sentCount >= (turn + 1) * samplesPerTurn) else begin
                errorCount++;
                $display("magnitude strobe for turn %0d came before the turn ended", turn);
            end
        end
    endtask

    task automatic checkSet(input bit isRf, input int turn);
        magVecT mags;
        int     first;
        int     count;
        int     shift;
        string  label;
        longint expected;
        longint actual;
        if (isRf) begin
            mags = rfMags;
            count = mtTurns * samplesPerTurn;
            label = {turnNameQ[turn], " rf"};
        end else begin
            mags = tbtMags;
            count = samplesPerTurn;
            label = {turnNameQ[turn], " tbt"};
        end
        first = (turn + 1) * samplesPerTurn - count;
        shift = isRf ? rfShiftQ[first + count - 1] : tbtShiftQ[first + count - 1];
        for (int ch = 0; ch < nAdc; ch++) begin
            expected = refMagnitude(first, count, ch, shift);
            actual = longint'(mags[ch]);
            checkCount++;
            assert (actual == expected) else begin
                errorCount++;
                $display("CHECK FAILED %s turn %0d ch %0d expected %0d actual %0d",
                         label, turn, ch, expected, actual);
            end
        end
    endtask

    // TBT after every turn and RF after every second turn
    task automatic compareStreams();
        bit arrived;
        for (int t = 0; t < totalTurns && !timedOut; t++) begin
            awaitStrobe(1'b0, t, arrived);
            if (arrived) begin
                checkSet(1'b0, t);
            end
            if (arrived && (t % mtTurns) == mtTurns - 1) begin
                awaitStrobe(1'b1, t, arrived);
                if (arrived) begin
                    checkSet(1'b1, t);
                end
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        rstN = 1'b0;
        adcValid = 1'b0;
        adc = '0;
        tbtSumShift = '0;
        rfSumShift = '0;
        seed = 27;
        sentCount = 0;
        checkCount = 0;
        errorCount = 0;
        timedOut = 1'b0;
        // strobes must stay quiet in reset
        repeat (5) begin
            @(negedge clk);
            assert (!tbtMagValid && !rfMagValid) else begin
                errorCount++;
                $display("magnitude strobe seen while reset was asserted");
            end
        end
        @(posedge clk);
        #1;
        rstN = 1'b1;
        fork
            begin
                ampC = '{12000, -8000, 3000, -25000};
                ampS = '{5000, 15000, -20000, -1000};
                sendToneTurns("tone", toneTurns);
                ampC = '{32767, -32767, 32767, 0};
                ampS = '{32767, 32767, 0, -32767};
                sendToneTurns("full scale", shiftTurns / 2);
                tbtSumShift = 4'd3;
                rfSumShift = 4'd5;
                sendToneTurns("shifted", shiftTurns / 2);
                tbtSumShift = 4'd1;
                rfSumShift = 4'd2;
                sendRandomTurns("random", randomTurns);
            end
            compareStreams();
        join
        $display("checks %0d errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* logic/bpmProcessingTop.sv */
`timescale 1ns/1ns
// BPM preliminary processing top level
// demodulation, turn and two-turn sums, shared magnitude engine

module bpmProcessingTop
    import bpmSignalPkg::*;
(
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  adcValid,
    input  adcVecT                adc,
    input  logic [shiftWidth-1:0] tbtSumShift,
    input  logic [shiftWidth-1:0] rfSumShift,
    output logic                  tbtMagValid,
    output logic                  rfMagValid,
    output magVecT                tbtMags,
    output magVecT                rfMags
);

    logic [phaseWidth-1:0] phase;
    logic                  tbtLatch;
    logic                  mtLatch;
    logic                  productValid;
    productVecT            products;
    logic                  tbtReady;
    sumVecT                tbtSums;
    logic                  rfReady;
    sumVecT                rfSums;
    logic                  start;
    sumT                   sumI;
    sumT                   sumQ;
    logic                  done;
    magT                   magnitude;

    //////////////////////////////
    // demodulation
    //////////////////////////////

    turnSequencer i_turnSequencer (
        .clk      (clk),
        .rstN     (rstN),
        .adcValid (adcValid),
        .phase    (phase),
        .tbtLatch (tbtLatch),
        .mtLatch  (mtLatch)
    );

    demodMixer i_demodMixer (
        .clk          (clk),
        .rstN         (rstN),
        .adcValid     (adcValid),
        .adc          (adc),
        .phase        (phase),
        .productValid (productValid),
        .products     (products)
    );

    // single turn sums
    turnAccumulator tbtAccumulator (
        .clk          (clk),
        .rstN         (rstN),
        .productValid (productValid),
        .products     (products),
        .latch        (tbtLatch),
        .sumShift     (tbtSumShift),
        .sumsReady    (tbtReady),
        .sums         (tbtSums)
    );

    // two turn sums
    turnAccumulator rfAccumulator (
        .clk          (clk),
        .rstN         (rstN),
        .productValid (productValid),
        .products     (products),
        .latch        (mtLatch),
        .sumShift     (rfSumShift),
        .sumsReady    (rfReady),
        .sums         (rfSums)
    );

    //////////////////////////////
    // magnitudes
    //////////////////////////////

    magnitudeArbiter i_magnitudeArbiter (
        .clk         (clk),
        .rstN        (rstN),
        .tbtReady    (tbtReady),
        .tbtSums     (tbtSums),
        .rfReady     (rfReady),
        .rfSums      (rfSums),
        .start       (start),
        .sumI        (sumI),
        .sumQ        (sumQ),
        .done        (done),
        .magnitude   (magnitude),
        .tbtMagValid (tbtMagValid),
        .rfMagValid  (rfMagValid),
        .tbtMags     (tbtMags),
        .rfMags      (rfMags)
    );

    sqrtMagnitude i_sqrtMagnitude (
        .clk       (clk),
        .rstN      (rstN),
        .start     (start),
        .sumI      (sumI),
        .sumQ      (sumQ),
        .done      (done),
        .magnitude (magnitude)
    );

endmodule

/* logic/magnitudeArbiter.sv */
`timescale 1ns/1ns
// magnitude arbiter
// shares one magnitude engine between the TBT and RF streams, TBT first

module magnitudeArbiter
    import bpmSignalPkg::*, bpmStreamPkg::*;
(
    input  logic   clk,
    input  logic   rstN,
    input  logic   tbtReady,
    input  sumVecT tbtSums,
    input  logic   rfReady,
    input  sumVecT rfSums,
    output logic   start,
    output sumT    sumI,
    output sumT    sumQ,
    input  logic   done,
    input  magT    magnitude,
    output logic   tbtMagValid,
    output logic   rfMagValid,
    output magVecT tbtMags,
    output magVecT rfMags
);

    engineStateT            state;
    streamT                 grant;
    logic [chanWidth-1:0]   channel;
    logic                   tbtPending;
    logic                   rfPending;
    logic                   lastResult;
    sumVecT                 tbtHold;
    sumVecT                 rfHold;

    //////////////////////////////
    // engine request side
    //////////////////////////////

    assign start = (state == engIssue);
    assign sumI = (grant == streamTbt) ? tbtHold.i[channel] : rfHold.i[channel];
    assign sumQ = (grant == streamTbt) ? tbtHold.q[channel] : rfHold.q[channel];
    assign lastResult = (state == engWait) && done && (channel == chanWidth'(nAdc - 1));

    always_ff @(posedge clk) begin
        if (tbtReady) begin
            tbtHold <= tbtSums;
        end
        if (rfReady) begin
            rfHold <= rfSums;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= engIdle;
            grant <= streamTbt;
            channel <= '0;
            tbtPending <= 1'b0;
            rfPending <= 1'b0;
            tbtMagValid <= 1'b0;
            rfMagValid <= 1'b0;
        end else begin
            tbtMagValid <= lastResult && (grant == streamTbt);
            rfMagValid <= lastResult && (grant == streamRf);
            // set stays pending until its last channel returns
            if (lastResult && grant == streamTbt) begin
                tbtPending <= 1'b0;
            end
            if (lastResult && grant == streamRf) begin
                rfPending <= 1'b0;
            end
            if (tbtReady) begin
                tbtPending <= 1'b1;
            end
            if (rfReady) begin
                rfPending <= 1'b1;
            end
            case (state)
                engIdle: begin
                    if (tbtPending || rfPending) begin
                        if (tbtPending) begin
                            grant <= streamTbt;
                        end else begin
                            grant <= streamRf;
                        end
                        channel <= '0;
                        state <= engIssue;
                    end
                end
                engIssue: begin
                    state <= engWait;
                end
                engWait: begin
                    if (lastResult) begin
                        state <= engIdle;
                    end else if (done) begin
                        channel <= channel + 1'b1;
                        state <= engIssue;
                    end
                end
                default: begin
                    state <= engIdle;
                end
            endcase
        end
    end

    //////////////////////////////
    // result side
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (state == engWait && done) begin
            if (grant == streamTbt) begin
                tbtMags[channel] <= magnitude;
            end else begin
                rfMags[channel] <= magnitude;
            end
        end
    end

endmodule

/* logic/sqrtMagnitude.sv */
`timescale 1ns/1ns
// square root magnitude engine
// floor(sqrt(I*I + Q*Q)), one root bit per cycle, saturated to the magnitude range

module sqrtMagnitude
    import bpmSignalPkg::*, bpmStreamPkg::*;
(
    input  logic clk,
    input  logic rstN,
    input  logic start,
    input  sumT  sumI,
    input  sumT  sumQ,
    output logic done,
    output magT  magnitude
);

    logic signed [2*sqrtCycles-1:0] squareI;
    logic signed [2*sqrtCycles-1:0] squareQ;
    logic [2*sqrtCycles-1:0]        radicand;
    logic [sqrtCycles+1:0]          remainder;
    logic [sqrtCycles-1:0]          root;
    logic [sqrtCountWidth-1:0]      iterCount;
    logic [sqrtCycles+3:0]          remShift;
    logic [sqrtCycles+3:0]          trial;
    logic [sqrtCycles+3:0]          remDiff;
    logic [sqrtCycles+1:0]          nextRem;
    logic [sqrtCycles-1:0]          nextRoot;

    always_comb begin
        squareI = (2*sqrtCycles)'(sumI) * (2*sqrtCycles)'(sumI);
        squareQ = (2*sqrtCycles)'(sumQ) * (2*sqrtCycles)'(sumQ);
    end

    // restoring digit step, two radicand bits in per cycle
    always_comb begin
        remShift = {remainder, radicand[2*sqrtCycles-1 -: 2]};
        trial = {2'b00, root, 2'b01};
        remDiff = remShift - trial;
        if (remShift >= trial) begin
            nextRem = remDiff[sqrtCycles+1:0];
            nextRoot = {root[sqrtCycles-2:0], 1'b1};
        end else begin
            nextRem = remShift[sqrtCycles+1:0];
            nextRoot = {root[sqrtCycles-2:0], 1'b0};
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            iterCount <= '0;
            done <= 1'b0;
        end else begin
            done <= (iterCount == sqrtCountWidth'(1));
            if (start) begin
                iterCount <= sqrtCountWidth'(sqrtCycles);
            end else if (iterCount != '0) begin
                iterCount <= iterCount - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            radicand <= squareI + squareQ;
            remainder <= '0;
            root <= '0;
        end else if (iterCount != '0) begin
            radicand <= radicand << 2;
            remainder <= nextRem;
            root <= nextRoot;
            // final bit, clamp anything past the magnitude width
            if (iterCount == sqrtCountWidth'(1)) begin
                magnitude <= (|nextRoot[sqrtCycles-1:magWidth]) ? '1 : nextRoot[magWidth-1:0];
            end
        end
    end

endmodule

/* logic/turnAccumulator.sv */
`timescale 1ns/1ns
// turn accumulator
// sums I/Q products per channel, releases shifted and saturated sums on latch

module turnAccumulator
    import bpmSignalPkg::*;
(
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  productValid,
    input  productVecT            products,
    input  logic                  latch,
    input  logic [shiftWidth-1:0] sumShift,
    output logic                  sumsReady,
    output sumVecT                sums
);

    accT accI [nAdc];
    accT accQ [nAdc];
    accT nextI [nAdc];
    accT nextQ [nAdc];

    // clamp to the signed sum range
    function automatic sumT saturate(input accT value);
        logic [accWidth-sumWidth:0] top;
        top = value[accWidth-1:sumWidth-1];
        if (top == '0 || top == '1) begin
            return sumT'(value);
        end
        if (value[accWidth-1]) begin
            return {1'b1, {(sumWidth-1){1'b0}}};
        end
        return {1'b0, {(sumWidth-1){1'b1}}};
    endfunction

    always_comb begin
        for (int ch = 0; ch < nAdc; ch++) begin
            nextI[ch] = accI[ch] + accT'(products.i[ch]);
            nextQ[ch] = accQ[ch] + accT'(products.q[ch]);
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            sumsReady <= 1'b0;
            for (int ch = 0; ch < nAdc; ch++) begin
                accI[ch] <= '0;
                accQ[ch] <= '0;
            end
        end else begin
            sumsReady <= productValid && latch;
            if (productValid) begin
                // the latched product closes this sum, next one starts empty
                for (int ch = 0; ch < nAdc; ch++) begin
                    accI[ch] <= latch ? '0 : nextI[ch];
                    accQ[ch] <= latch ? '0 : nextQ[ch];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (productValid && latch) begin
            for (int ch = 0; ch < nAdc; ch++) begin
                sums.i[ch] <= saturate(nextI[ch] >>> sumShift);
                sums.q[ch] <= saturate(nextQ[ch] >>> sumShift);
            end
        end
    end

endmodule

/* logic/demodMixer.sv */
`timescale 1ns/1ns
// synchronous demodulation mixer
// multiplies every ADC channel by the LO cosine and sine, scaled and registered

module demodMixer
    import bpmSignalPkg::*;
(
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  adcValid,
    input  adcVecT                adc,
    input  logic [phaseWidth-1:0] phase,
    output logic                  productValid,
    output productVecT            products
);

`include "loTable.svh"

    logic signed [loWidth-1:0]          loCos;
    logic signed [loWidth-1:0]          loSin;
    logic signed [adcWidth+loWidth-1:0] rawI [nAdc];
    logic signed [adcWidth+loWidth-1:0] rawQ [nAdc];

    assign loCos = loCosTable[phase];
    assign loSin = loSinTable[phase];

    // full width products before scaling
    always_comb begin
        for (int ch = 0; ch < nAdc; ch++) begin
            rawI[ch] = adc[ch] * loCos;
            rawQ[ch] = adc[ch] * loSin;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            productValid <= 1'b0;
        end else begin
            productValid <= adcValid;
        end
    end

    always_ff @(posedge clk) begin
        if (adcValid) begin
            for (int ch = 0; ch < nAdc; ch++) begin
                // drop the LO gain, rounding toward minus infinity
                products.i[ch] <= productT'(rawI[ch] >>> productShift);
                products.q[ch] <= productT'(rawQ[ch] >>> productShift);
            end
        end
    end

endmodule

/* logic/turnSequencer.sv */
`timescale 1ns/1ns
// turn sequencer
// tracks the sample phase within a turn and flags turn and two-turn ends

module turnSequencer
    import bpmSignalPkg::*, bpmStreamPkg::*;
(
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  adcValid,
    output logic [phaseWidth-1:0] phase,
    output logic                  tbtLatch,
    output logic                  mtLatch
);

    logic [mtTurnWidth-1:0] turnCount;
    logic                   lastSample;
    logic                   lastTurn;

    assign lastSample = (phase == phaseWidth'(samplesPerTurn - 1));
    assign lastTurn = (turnCount == mtTurnWidth'(mtTurns - 1));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            phase <= '0;
            turnCount <= '0;
            tbtLatch <= 1'b0;
            mtLatch <= 1'b0;
        end else begin
            // one cycle late so the flags sit beside the mixer products
            tbtLatch <= adcValid && lastSample;
            mtLatch <= adcValid && lastSample && lastTurn;
            if (adcValid) begin
                if (lastSample) begin
                    phase <= '0;
                    if (lastTurn) begin
                        turnCount <= '0;
                    end else begin
                        turnCount <= turnCount + 1'b1;
                    end
                end else begin
                    phase <= phase + 1'b1;
                end
            end
        end
    end

endmodule

/* logic/bpmStreamPkg.sv */
// BPM stream package
// stream and engine state encodings, stream timing constants

package bpmStreamPkg;

    typedef enum logic {
        streamTbt,
        streamRf
    } streamT;

    typedef enum logic [1:0] {
        engIdle,
        engIssue,
        engWait
    } engineStateT;

    // turns per multi-turn RF sum
    localparam int mtTurns = 2;
    localparam int mtTurnWidth = $clog2(mtTurns);

    // one root bit per iteration
    localparam int sqrtCycles = 27;
    localparam int sqrtCountWidth = $clog2(sqrtCycles + 1);

endpackage

/* logic/bpmSignalPkg.sv */
// BPM signal package
// widths, channel count, turn length and data types of the demodulation path

package bpmSignalPkg;

    // ADC and local oscillator
    localparam int nAdc = 4;
    localparam int chanWidth = $clog2(nAdc);
    localparam int adcWidth = 16;
    localparam int loWidth = 18;
    localparam int loAmplitude = (1 << 17) - 1;

    // products, scaled down after the multiply
    localparam int productShift = 17;
    localparam int productWidth = 20;

    // turn structure
    localparam int samplesPerTurn = 8;
    localparam int phaseWidth = 3;

    // sums and magnitudes
    localparam int accWidth = 32;
    localparam int sumWidth = 26;
    localparam int magWidth = 26;
    localparam int shiftWidth = 4;

    typedef logic signed [adcWidth-1:0] adcSampleT;
    typedef adcSampleT [nAdc-1:0] adcVecT;

    typedef logic signed [productWidth-1:0] productT;
    typedef struct packed {
        productT [nAdc-1:0] i;
        productT [nAdc-1:0] q;
    } productVecT;

    typedef logic signed [accWidth-1:0] accT;

    typedef logic signed [sumWidth-1:0] sumT;
    typedef struct packed {
        sumT [nAdc-1:0] i;
        sumT [nAdc-1:0] q;
    } sumVecT;

    typedef logic [magWidth-1:0] magT;
    typedef magT [nAdc-1:0] magVecT;

endpackage

/* include/loTable.svh */
// local oscillator table
// cosine and sine at a quarter of the sample rate, indexed by turn phase
`ifndef LO_TABLE_SVH
`define LO_TABLE_SVH

localparam logic signed [loWidth-1:0] loPeak = loWidth'(loAmplitude);

localparam logic signed [loWidth-1:0] loCosTable [samplesPerTurn] = '{
    loPeak, '0, -loPeak, '0, loPeak, '0, -loPeak, '0
};

localparam logic signed [loWidth-1:0] loSinTable [samplesPerTurn] = '{
    '0, loPeak, '0, -loPeak, '0, loPeak, '0, -loPeak
};

`endif
